//--- csr_pkg.sv
package csr_pkg;

    // one register or pc word
    typedef logic [63:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    // register select inside one trap bank
    typedef logic [2:0] reg_sel_t;

    // redirect kind from the trap controller
    typedef logic [1:0] redir_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_e;

    typedef struct packed {
        logic  valid;
        xlen_t cause;
        xlen_t epc;
        xlen_t tval;
    } except_t;

    typedef struct packed {
        logic     trap;
        xlen_t    epc;
        xlen_t    cause;
        xlen_t    tval;
        reg_sel_t wr_sel;
        logic     wr_en;
        xlen_t    wr_data;
    } bank_upd_t;

    typedef struct packed {
        xlen_t tvec;
        xlen_t scratch;
        xlen_t epc;
        xlen_t cause;
        xlen_t tval;
    } bank_regs_t;

    typedef struct packed {
        logic [1:0] mpp;
        logic       spp;
        logic       mpie;
        logic       spie;
        logic       mie;
        logic       sie;
    } status_t;

    // bank index follows csr address bit 9
    localparam int NUM_BANKS = 2;
    localparam int BANK_S    = 0;
    localparam int BANK_M    = 1;

    localparam reg_sel_t BANK_TVEC    = 3'd0;
    localparam reg_sel_t BANK_SCRATCH = 3'd1;
    localparam reg_sel_t BANK_EPC     = 3'd2;
    localparam reg_sel_t BANK_CAUSE   = 3'd3;
    localparam reg_sel_t BANK_TVAL    = 3'd4;

    localparam redir_t REDIR_NONE = 2'd0;
    localparam redir_t REDIR_TRAP = 2'd1;
    localparam redir_t REDIR_RET  = 2'd2;

    localparam csr_addr_t CSR_SSTATUS  = 12'h100;
    localparam csr_addr_t CSR_STVEC    = 12'h105;
    localparam csr_addr_t CSR_SSCRATCH = 12'h140;
    localparam csr_addr_t CSR_SEPC     = 12'h141;
    localparam csr_addr_t CSR_SCAUSE   = 12'h142;
    localparam csr_addr_t CSR_STVAL    = 12'h143;
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MEDELEG  = 12'h302;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;

endpackage

//--- trap_ctrl.sv
module trap_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_wb,
    input  logic               csr_we_wb,
    input  csr_pkg::csr_addr_t csr_addr_wb,
    input  csr_pkg::xlen_t     csr_val_wb,
    input  csr_pkg::xlen_t     pc_wb,
    input  logic [1:0]         csr_ret_wb,
    input  csr_pkg::except_t   except_wb,
    output csr_pkg::bank_upd_t bank_upd [csr_pkg::NUM_BANKS],
    output csr_pkg::status_t   status,
    output csr_pkg::xlen_t     medeleg,
    output csr_pkg::priv_e     priv,
    output logic               switch_mode,
    output csr_pkg::redir_t    redir_kind,
    output logic               redir_bank
);

    import csr_pkg::*;

    logic     exc;
    logic     deleg;
    logic     s_trap;
    logic     m_trap;
    logic     s_ret;
    logic     m_ret;
    logic     we;
    logic     wr_hit;
    reg_sel_t wr_sel;
    xlen_t    trap_epc;

    assign exc = except_wb.valid & valid_wb;
    assign we  = valid_wb & csr_we_wb;

    // causes above 63 never delegate
    assign deleg  = (except_wb.cause[63:6] == '0) & medeleg[except_wb.cause[5:0]];
    assign s_trap = exc & (priv == PRIV_S) & deleg;
    assign m_trap = exc & ~s_trap;

    // returns lose to a trap in the same cycle
    assign s_ret = csr_ret_wb[0] & ~exc;
    assign m_ret = csr_ret_wb[1] & ~exc;

    assign switch_mode = s_trap | m_trap | s_ret | m_ret;

    always_comb begin
        if (exc) begin
            redir_kind = REDIR_TRAP;
            redir_bank = m_trap;
        end else if (m_ret) begin
            redir_kind = REDIR_RET;
            redir_bank = 1'b1;
        end else if (s_ret) begin
            redir_kind = REDIR_RET;
            redir_bank = 1'b0;
        end else begin
            redir_kind = REDIR_NONE;
            redir_bank = 1'b0;
        end
    end

    // register within a bank, bank itself from address bit 9
    always_comb begin
        wr_hit = 1'b1;
        wr_sel = BANK_TVEC;
        case (csr_addr_wb)
            CSR_STVEC, CSR_MTVEC:       wr_sel = BANK_TVEC;
            CSR_SSCRATCH, CSR_MSCRATCH: wr_sel = BANK_SCRATCH;
            CSR_SEPC, CSR_MEPC:         wr_sel = BANK_EPC;
            CSR_SCAUSE, CSR_MCAUSE:     wr_sel = BANK_CAUSE;
            CSR_STVAL, CSR_MTVAL:       wr_sel = BANK_TVAL;
            default:                    wr_hit = 1'b0;
        endcase
    end

    assign trap_epc = except_wb.valid ? except_wb.epc : pc_wb;

    always_comb begin
        for (int k = 0; k < NUM_BANKS; k++) begin
            bank_upd[k].trap    = (k == BANK_M) ? m_trap : s_trap;
            bank_upd[k].epc     = trap_epc;
            bank_upd[k].cause   = except_wb.cause;
            bank_upd[k].tval    = except_wb.tval;
            bank_upd[k].wr_sel  = wr_sel;
            bank_upd[k].wr_en   = we & wr_hit & (int'(csr_addr_wb[9]) == k);
            bank_upd[k].wr_data = csr_val_wb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv   <= PRIV_M;
            status <= '0;
        end else if (m_trap) begin
            priv        <= PRIV_M;
            status.mpie <= status.mie;
            status.mie  <= 1'b0;
            status.mpp  <= priv;
        end else if (s_trap) begin
            priv        <= PRIV_S;
            status.spie <= status.sie;
            status.sie  <= 1'b0;
            status.spp  <= priv[0];
        end else if (m_ret) begin
            priv        <= priv_e'(status.mpp);
            status.mie  <= status.mpie;
            status.mpie <= 1'b1;
            status.mpp  <= 2'b00;
        end else if (s_ret) begin
            priv        <= status.spp ? PRIV_S : PRIV_U;
            status.sie  <= status.spie;
            status.spie <= 1'b1;
            status.spp  <= 1'b0;
        end else if (we && csr_addr_wb == CSR_MSTATUS) begin
            status.sie  <= csr_val_wb[1];
            status.mie  <= csr_val_wb[3];
            status.spie <= csr_val_wb[5];
            status.mpie <= csr_val_wb[7];
            status.spp  <= csr_val_wb[8];
            status.mpp  <= csr_val_wb[12:11];
        end else if (we && csr_addr_wb == CSR_SSTATUS) begin
            status.sie  <= csr_val_wb[1];
            status.spie <= csr_val_wb[5];
            status.spp  <= csr_val_wb[8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            medeleg <= '0;
        end else if (we && csr_addr_wb == CSR_MEDELEG) begin
            medeleg <= csr_val_wb;
        end
    end

    a_one_trap_bank: assert property (@(posedge clk) disable iff (rst)
        !(bank_upd[BANK_S].trap && bank_upd[BANK_M].trap))
        else $error("trap strobed into both banks");

    // an mret from a reserved mpp would land here
    a_priv_legal: assert property (@(posedge clk) disable iff (rst) priv != 2'b10)
        else $error("priv holds reserved level");

endmodule

//--- trap_bank.sv
module trap_bank (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::bank_upd_t  upd,
    output csr_pkg::bank_regs_t regs
);

    import csr_pkg::*;

    bank_regs_t regs_q;

    assign regs = regs_q;

    // software write first
    always_ff @(posedge clk) begin
        if (rst) begin
            regs_q <= '0;
        end else begin
            if (upd.wr_en) begin
                case (upd.wr_sel)
                    BANK_TVEC: begin
                        regs_q.tvec <= upd.wr_data;
                    end
                    BANK_SCRATCH: begin
                        regs_q.scratch <= upd.wr_data;
                    end
                    BANK_EPC: begin
                        regs_q.epc <= upd.wr_data;
                    end
                    BANK_CAUSE: begin
                        regs_q.cause <= upd.wr_data;
                    end
                    BANK_TVAL: begin
                        regs_q.tval <= upd.wr_data;
                    end
                    default: begin
                        regs_q.tvec <= regs_q.tvec;
                    end
                endcase
            end
            // trap loads come last so they override a same-cycle write
            if (upd.trap) begin
                regs_q.epc   <= upd.epc;
                regs_q.cause <= upd.cause;
                regs_q.tval  <= upd.tval;
            end
        end
    end

    a_trap_wins: assert property (@(posedge clk) disable iff (rst)
        (upd.trap && upd.wr_en) |=>
            (regs.epc == $past(upd.epc)) &&
            (regs.cause == $past(upd.cause)) &&
            (regs.tval == $past(upd.tval)))
        else $error("csr write overrode trap update");

endmodule

//--- csr_read_mux.sv
module csr_read_mux (
    input  csr_pkg::csr_addr_t  csr_addr_id,
    input  csr_pkg::bank_regs_t banks [csr_pkg::NUM_BANKS],
    input  csr_pkg::status_t    status,
    input  csr_pkg::xlen_t      medeleg,
    input  csr_pkg::redir_t     redir_kind,
    input  logic                redir_bank,
    output csr_pkg::xlen_t      csr_val_id,
    output csr_pkg::xlen_t      pc_csr
);

    import csr_pkg::*;

    xlen_t      mstatus_view;
    xlen_t      sstatus_view;
    bank_regs_t s_regs;
    bank_regs_t m_regs;

    assign s_regs = banks[BANK_S];
    assign m_regs = banks[BANK_M];

    // architectural bit positions, everything else zero
    always_comb begin
        mstatus_view        = '0;
        mstatus_view[1]     = status.sie;
        mstatus_view[3]     = status.mie;
        mstatus_view[5]     = status.spie;
        mstatus_view[7]     = status.mpie;
        mstatus_view[8]     = status.spp;
        mstatus_view[12:11] = status.mpp;
    end

    // supervisor view hides the M fields
    always_comb begin
        sstatus_view    = '0;
        sstatus_view[1] = status.sie;
        sstatus_view[5] = status.spie;
        sstatus_view[8] = status.spp;
    end

    always_comb begin
        case (csr_addr_id)
            CSR_SSTATUS:  csr_val_id = sstatus_view;
            CSR_STVEC:    csr_val_id = s_regs.tvec;
            CSR_SSCRATCH: csr_val_id = s_regs.scratch;
            CSR_SEPC:     csr_val_id = s_regs.epc;
            CSR_SCAUSE:   csr_val_id = s_regs.cause;
            CSR_STVAL:    csr_val_id = s_regs.tval;
            CSR_MSTATUS:  csr_val_id = mstatus_view;
            CSR_MEDELEG:  csr_val_id = medeleg;
            CSR_MTVEC:    csr_val_id = m_regs.tvec;
            CSR_MSCRATCH: csr_val_id = m_regs.scratch;
            CSR_MEPC:     csr_val_id = m_regs.epc;
            CSR_MCAUSE:   csr_val_id = m_regs.cause;
            CSR_MTVAL:    csr_val_id = m_regs.tval;
            default:      csr_val_id = '0;
        endcase
    end

    // redirect target from the selected bank
    always_comb begin
        case (redir_kind)
            REDIR_TRAP: pc_csr = banks[redir_bank].tvec;
            REDIR_RET:  pc_csr = banks[redir_bank].epc;
            default:    pc_csr = '0;
        endcase
    end

endmodule

//--- csr_unit.sv
module csr_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_wb,
    input  logic               csr_we_wb,
    input  csr_pkg::csr_addr_t csr_addr_wb,
    input  csr_pkg::xlen_t     csr_val_wb,
    input  csr_pkg::csr_addr_t csr_addr_id,
    input  csr_pkg::xlen_t     pc_wb,
    input  logic [1:0]         csr_ret_wb,
    input  csr_pkg::except_t   except_wb,
    output csr_pkg::xlen_t     csr_val_id,
    output csr_pkg::xlen_t     pc_csr,
    output csr_pkg::priv_e     priv,
    output logic               switch_mode
);

    import csr_pkg::*;

    bank_upd_t  bank_upd  [NUM_BANKS];
    bank_regs_t bank_regs [NUM_BANKS];
    status_t    status;
    xlen_t      medeleg;
    redir_t     redir_kind;
    logic       redir_bank;

    trap_ctrl trap_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .valid_wb   (valid_wb),
        .csr_we_wb  (csr_we_wb),
        .csr_addr_wb(csr_addr_wb),
        .csr_val_wb (csr_val_wb),
        .pc_wb      (pc_wb),
        .csr_ret_wb (csr_ret_wb),
        .except_wb  (except_wb),
        .bank_upd   (bank_upd),
        .status     (status),
        .medeleg    (medeleg),
        .priv       (priv),
        .switch_mode(switch_mode),
        .redir_kind (redir_kind),
        .redir_bank (redir_bank)
    );

    // bank 0 is supervisor, bank 1 machine
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        trap_bank trap_bank_inst (
            .clk (clk),
            .rst (rst),
            .upd (bank_upd[i]),
            .regs(bank_regs[i])
        );
    end

    csr_read_mux csr_read_mux_inst (
        .csr_addr_id(csr_addr_id),
        .banks      (bank_regs),
        .status     (status),
        .medeleg    (medeleg),
        .redir_kind (redir_kind),
        .redir_bank (redir_bank),
        .csr_val_id (csr_val_id),
        .pc_csr     (pc_csr)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // synchronous reset, released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tb_csr_unit.sv
module tb_csr_unit;

    import csr_pkg::*;

    localparam int RESET_TIMEOUT = 50;
    localparam int FIELD_COUNT   = 15;

    logic       clk;
    logic       rst;
    logic       valid_wb;
    logic       csr_we_wb;
    csr_addr_t  csr_addr_wb;
    xlen_t      csr_val_wb;
    csr_addr_t  csr_addr_id;
    xlen_t      pc_wb;
    logic [1:0] csr_ret_wb;
    except_t    except_wb;
    xlen_t      csr_val_id;
    xlen_t      pc_csr;
    priv_e      priv;
    logic       switch_mode;

    // fields of one stim line
    xlen_t f_valid;
    xlen_t f_we;
    xlen_t f_addr_wb;
    xlen_t f_val_wb;
    xlen_t f_ret;
    xlen_t f_pc;
    xlen_t f_exc;
    xlen_t f_cause;
    xlen_t f_epc;
    xlen_t f_tval;
    xlen_t f_addr_id;
    xlen_t x_pc;
    xlen_t x_sw;
    xlen_t x_priv;
    xlen_t x_val;

    int    fd;
    int    n;
    int    waited;
    int    vec_num;
    string line;

    tb_clock_gen clock_gen_inst (
        .clk(clk),
        .rst(rst)
    );

    csr_unit csr_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .valid_wb   (valid_wb),
        .csr_we_wb  (csr_we_wb),
        .csr_addr_wb(csr_addr_wb),
        .csr_val_wb (csr_val_wb),
        .csr_addr_id(csr_addr_id),
        .pc_wb      (pc_wb),
        .csr_ret_wb (csr_ret_wb),
        .except_wb  (except_wb),
        .csr_val_id (csr_val_id),
        .pc_csr     (pc_csr),
        .priv       (priv),
        .switch_mode(switch_mode)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at time %0t: vector %0d %s is %h, expected %h",
                $time, vec_num, what, got, exp));
        end
    endtask

    task automatic drive_idle();
        valid_wb    <= 1'b0;
        csr_we_wb   <= 1'b0;
        csr_addr_wb <= '0;
        csr_val_wb  <= '0;
        csr_ret_wb  <= '0;
        pc_wb       <= '0;
        except_wb   <= '0;
        csr_addr_id <= '0;
    endtask

    initial begin
        valid_wb    = 1'b0;
        csr_we_wb   = 1'b0;
        csr_addr_wb = '0;
        csr_val_wb  = '0;
        csr_ret_wb  = '0;
        pc_wb       = '0;
        except_wb   = '0;
        csr_addr_id = '0;
        vec_num     = 0;

        fd = $fopen("csr_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file csr_stim.txt");
        end

        waited = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                abort_run("reset was never released");
            end
        end

        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f_valid, f_we, f_addr_wb, f_val_wb, f_ret, f_pc, f_exc, f_cause,
                    f_epc, f_tval, f_addr_id, x_pc, x_sw, x_priv, x_val);
                vec_num++;
                if (n != FIELD_COUNT) begin
                    abort_run($sformatf("stimulus line %0d does not hold %0d hex fields",
                        vec_num, FIELD_COUNT));
                end
                @(posedge clk);
                valid_wb        <= f_valid[0];
                csr_we_wb       <= f_we[0];
                csr_addr_wb     <= f_addr_wb[11:0];
                csr_val_wb      <= f_val_wb;
                csr_ret_wb      <= f_ret[1:0];
                pc_wb           <= f_pc;
                except_wb.valid <= f_exc[0];
                except_wb.cause <= f_cause;
                except_wb.epc   <= f_epc;
                except_wb.tval  <= f_tval;
                csr_addr_id     <= f_addr_id[11:0];
                // outputs settle well before the next edge
                @(negedge clk);
                compare_value(pc_csr, x_pc, "pc_csr");
                compare_value(64'(switch_mode), x_sw, "switch_mode");
                compare_value(64'(priv), x_priv, "priv");
                compare_value(csr_val_id, x_val, "csr_val_id");
            end
        end
        $fclose(fd);

        if (vec_num == 0) begin
            abort_run("the stimulus file held no vectors");
        end

        @(posedge clk);
        drive_idle();
        @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- csr_stim.txt
# valid we addr_wb wdata ret pc exc cause epc tval addr_id | exp_pc exp_sw exp_priv exp_rdata
# all hex; ret bit 0 is sret, bit 1 is mret; exp_rdata is the read before this line's update
1 0 000 0 0 0 0 0 0 0 300 0 0 3 0
1 0 000 0 0 0 0 0 0 0 305 0 0 3 0
1 0 000 0 0 0 0 0 0 0 302 0 0 3 0
1 0 000 0 0 0 0 0 0 0 123 0 0 3 0
1 1 305 80000100 0 0 0 0 0 0 000 0 0 3 0
1 1 340 1111 0 0 0 0 0 0 305 0 0 3 80000100
1 1 341 2222 0 0 0 0 0 0 340 0 0 3 1111
1 1 342 3333 0 0 0 0 0 0 341 0 0 3 2222
1 1 343 4444 0 0 0 0 0 0 342 0 0 3 3333
1 1 105 80000200 0 0 0 0 0 0 343 0 0 3 4444
1 1 140 5555 0 0 0 0 0 0 105 0 0 3 80000200
1 1 141 6666 0 0 0 0 0 0 140 0 0 3 5555
1 1 142 7777 0 0 0 0 0 0 141 0 0 3 6666
1 1 143 8888 0 0 0 0 0 0 142 0 0 3 7777
1 1 302 4 0 0 0 0 0 0 143 0 0 3 8888
1 1 300 ffffffffffffffff 0 0 0 0 0 0 302 0 0 3 4
1 1 100 0 0 0 0 0 0 0 300 0 0 3 19aa
1 1 100 ffffffffffffffff 0 0 0 0 0 0 300 0 0 3 1888
1 0 000 0 0 0 0 0 0 0 100 0 0 3 122
1 1 300 8 0 0 0 0 0 0 100 0 0 3 122
1 0 000 0 0 0 0 0 0 0 300 0 0 3 8
1 0 000 0 0 1000 1 2 1000 dead 300 80000100 1 3 8
1 0 000 0 0 0 0 0 0 0 341 0 0 3 1000
1 0 000 0 0 0 0 0 0 0 342 0 0 3 2
1 0 000 0 0 0 0 0 0 0 343 0 0 3 dead
1 0 000 0 0 0 0 0 0 0 300 0 0 3 1880
1 1 300 880 0 0 0 0 0 0 300 0 0 3 1880
1 1 341 2000 0 0 0 0 0 0 300 0 0 3 880
1 0 000 0 2 0 0 0 0 0 341 2000 1 3 2000
1 0 000 0 0 0 0 0 0 0 300 0 0 1 88
1 1 100 2 0 0 0 0 0 0 300 0 0 1 88
1 0 000 0 0 3000 1 2 3000 beef 100 80000200 1 1 2
1 0 000 0 0 0 0 0 0 0 141 0 0 1 3000
1 0 000 0 0 0 0 0 0 0 142 0 0 1 2
1 0 000 0 0 0 0 0 0 0 143 0 0 1 beef
1 0 000 0 0 0 0 0 0 0 100 0 0 1 120
1 0 000 0 0 0 0 0 0 0 341 0 0 1 2000
1 1 141 4000 0 0 0 0 0 0 300 0 0 1 1a8
1 0 000 0 1 0 0 0 0 0 141 4000 1 1 4000
1 0 000 0 0 0 0 0 0 0 100 0 0 1 22
1 0 000 0 1 0 0 0 0 0 300 4000 1 1 aa
1 0 000 0 0 0 0 0 0 0 300 0 0 0 aa
1 0 000 0 2 5000 1 8 5000 0 300 80000100 1 0 aa
1 0 000 0 0 0 0 0 0 0 341 0 0 3 5000
1 0 000 0 0 0 0 0 0 0 342 0 0 3 8
1 0 000 0 0 0 0 0 0 0 300 0 0 3 a2
1 1 341 9999 0 6000 1 2 6000 1234 300 80000100 1 3 a2
1 0 000 0 0 0 0 0 0 0 341 0 0 3 6000
1 0 000 0 0 0 0 0 0 0 342 0 0 3 2
1 0 000 0 0 0 0 0 0 0 343 0 0 3 1234
1 0 000 0 0 0 0 0 0 0 141 0 0 3 4000
1 0 000 0 0 0 0 0 0 0 300 0 0 3 1822
0 0 000 0 0 7000 1 2 7000 4321 341 0 0 3 6000
1 0 000 0 0 0 0 0 0 0 341 0 0 3 6000
1 0 000 0 2 0 0 0 0 0 300 6000 1 3 1822
1 0 000 0 0 0 0 0 0 0 300 0 0 3 a2

//--- files.f
csr_pkg.sv
trap_ctrl.sv
trap_bank.sv
csr_read_mux.sv
csr_unit.sv
tb_clock_gen.sv
tb_csr_unit.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module tb_csr_unit \
		--Mdir obj_dir -o sim_csr
	./obj_dir/sim_csr > sim.log 2>&1; cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
